//--- verilog/mrd_pkg.sv
package mrd_pkg;

	// sample width, each of real and imaginary part
	localparam int dw = 16;

	// lanes per input beat
	localparam int n_lane = 4;

	// one bank per residue of a radix-7 stage
	localparam int n_bank = 7;

	// cycles in st_sink before the frame is dropped
	localparam logic [11:0] over_limit = 12'd2047;

	typedef enum logic [1:0] {
		st_idle,
		st_sink,
		st_source
	} mrd_state_e;

endpackage

//--- verilog/mrd_if.sv
`timescale 1ns/1ns

// 4-lane complex input stream
interface mrd_st_if import mrd_pkg::*; ();

	logic                valid;
	logic signed [dw-1:0] din_real [n_lane];
	logic signed [dw-1:0] din_imag [n_lane];

	modport src (output valid, din_real, din_imag);
	modport snk (input valid, din_real, din_imag);

endinterface

// one write port per bank
interface mrd_mem_wr import mrd_pkg::*; #(parameter int w_addr = 8) ();

	logic [n_bank-1:0]    wren;
	logic [w_addr-1:0]    wraddr [n_bank];
	logic signed [dw-1:0] din_real [n_bank];
	logic signed [dw-1:0] din_imag [n_bank];

	modport wr (output wren, wraddr, din_real, din_imag);
	modport ram (input wren, wraddr, din_real, din_imag);

endinterface

//--- verilog/mrd_sink.sv
`timescale 1ns/1ns

module mrd_sink import mrd_pkg::*; #(
	parameter int w_addr = 8
) (
	input  logic         clk,
	input  logic         rst_n,
	input  mrd_state_e   fsm,
	mrd_st_if.snk        in_data,
	mrd_mem_wr.wr        wr_ram,
	output logic         sink_end,
	output logic         over_time,
	output logic [w_addr:0] frame_beats
);

	localparam int w_lane = $clog2(n_lane);

	logic [2:0]        bank_idx [n_lane];
	logic [w_addr-1:0] lane_row [n_lane];

	logic [n_bank-1:0] bank_hit;
	logic [w_lane-1:0] bank_sel [n_bank];

	logic              valid_q;
	logic [w_addr:0]   beat_cnt;
	logic [11:0]       cnt_over;

	// lane l of beat b sits at bank (4b+l) mod 7, row advances when the index wraps
	always_ff @(posedge clk) begin
		for (int l = 0; l < n_lane; l++) begin
			if (!rst_n || !in_data.valid) begin
				bank_idx[l] <= 3'(l);
				lane_row[l] <= '0;
			end else if (bank_idx[l] < 3'(n_bank - n_lane)) begin
				bank_idx[l] <= bank_idx[l] + 3'(n_lane);
			end else begin
				bank_idx[l] <= bank_idx[l] - 3'(n_bank - n_lane);
				lane_row[l] <= lane_row[l] + 1'b1;
			end
		end
	end

	// which lane, if any, lands on each bank this beat
	always_comb begin
		for (int b = 0; b < n_bank; b++) begin
			bank_hit[b] = 1'b0;
			bank_sel[b] = '0;
			for (int l = 0; l < n_lane; l++) begin
				if (bank_idx[l] == 3'(b)) begin
					bank_hit[b] = 1'b1;
					bank_sel[b] = w_lane'(l);
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			wr_ram.wren <= '0;
		else
			wr_ram.wren <= in_data.valid ? bank_hit : '0;
	end

	// payload is only meaningful where wren is set
	always_ff @(posedge clk) begin
		for (int b = 0; b < n_bank; b++) begin
			wr_ram.wraddr[b]   <= lane_row[bank_sel[b]];
			wr_ram.din_real[b] <= in_data.din_real[bank_sel[b]];
			wr_ram.din_imag[b] <= in_data.din_imag[bank_sel[b]];
		end
	end

	// frame length, end-of-frame strobe and sink watchdog
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid_q     <= 1'b0;
			beat_cnt    <= '0;
			frame_beats <= '0;
			sink_end    <= 1'b0;
			cnt_over    <= '0;
			over_time   <= 1'b0;
		end else begin
			valid_q  <= in_data.valid;
			beat_cnt <= in_data.valid ? beat_cnt + 1'b1 : '0;
			sink_end <= !in_data.valid && valid_q;
			if (!in_data.valid && valid_q)
				frame_beats <= beat_cnt;
			cnt_over  <= (fsm == st_sink) ? cnt_over + 12'd1 : 12'd0;
			over_time <= (cnt_over == over_limit);
		end
	end

	for (genvar a = 0; a < n_lane; a++) begin : g_chk_a
		for (genvar c = a + 1; c < n_lane; c++) begin : g_chk_c
			a_lane_distinct: assert property (@(posedge clk) disable iff (!rst_n)
				in_data.valid |-> bank_idx[a] != bank_idx[c]);
		end
	end

	// no back-pressure, so a beat during readout would be lost
	a_no_valid_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		fsm == st_source |-> !in_data.valid);

endmodule

//--- verilog/mrd_fsm.sv
`timescale 1ns/1ns

module mrd_fsm import mrd_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic       sink_end,
	input  logic       over_time,
	input  logic       src_done,
	output mrd_state_e fsm
);

	logic valid_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fsm     <= st_idle;
			valid_q <= 1'b0;
		end else begin
			valid_q <= in_valid;
			case (fsm)
				st_idle: begin
					// only a fresh rise starts a frame, a dropped frame still holding valid is ignored
					if (in_valid && !valid_q)
						fsm <= st_sink;
				end
				st_sink: begin
					if (over_time)
						fsm <= st_idle;
					else if (sink_end)
						fsm <= st_source;
				end
				st_source: begin
					if (src_done)
						fsm <= st_idle;
				end
				default: fsm <= st_idle;
			endcase
		end
	end

	a_source_from_sink: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fsm == st_source) |-> $past(fsm) == st_sink);

endmodule

//--- verilog/mrd_bank_ram.sv
`timescale 1ns/1ns

module mrd_bank_ram import mrd_pkg::*; #(
	parameter int w_addr = 8
) (
	input  logic                clk,
	mrd_mem_wr.ram              wr_ram,
	input  logic                rd_en,
	input  logic [2:0]          rd_bank,
	input  logic [w_addr-1:0]   rd_addr,
	output logic signed [dw-1:0] rd_real,
	output logic signed [dw-1:0] rd_imag
);

	localparam int depth = 2 ** w_addr;

	logic signed [dw-1:0] mem_real [n_bank][depth];
	logic signed [dw-1:0] mem_imag [n_bank][depth];

	// each bank has its own write enable and address
	always_ff @(posedge clk) begin
		for (int b = 0; b < n_bank; b++) begin
			if (wr_ram.wren[b]) begin
				mem_real[b][wr_ram.wraddr[b]] <= wr_ram.din_real[b];
				mem_imag[b][wr_ram.wraddr[b]] <= wr_ram.din_imag[b];
			end
		end
	end

	// shared read port, one word per cycle
	always_ff @(posedge clk) begin
		if (rd_en) begin
			rd_real <= mem_real[rd_bank][rd_addr];
			rd_imag <= mem_imag[rd_bank][rd_addr];
		end
	end

	a_rd_bank_range: assert property (@(posedge clk)
		rd_en |-> rd_bank < 3'(n_bank));

endmodule

//--- verilog/mrd_source.sv
`timescale 1ns/1ns

module mrd_source import mrd_pkg::*; #(
	parameter int w_addr = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mrd_state_e          fsm,
	input  logic [w_addr:0]     frame_beats,
	output logic                rd_en,
	output logic [2:0]          rd_bank,
	output logic [w_addr-1:0]   rd_addr,
	input  logic signed [dw-1:0] rd_real,
	input  logic signed [dw-1:0] rd_imag,
	output logic                out_valid,
	output logic signed [dw-1:0] out_real,
	output logic signed [dw-1:0] out_imag,
	output logic                out_last,
	output logic                src_done
);

	logic [w_addr+2:0] smp_cnt;
	logic [w_addr+2:0] smp_total;
	logic              rd_stop;
	logic              rd_last;

	// four samples per beat
	assign smp_total = {frame_beats, 2'b00};
	assign rd_last   = (smp_cnt == smp_total - 1'b1);
	assign rd_en     = (fsm == st_source) && !rd_stop;

	// sample k lives at bank k mod 7, row k div 7
	always_ff @(posedge clk) begin
		if (!rst_n || fsm != st_source) begin
			rd_bank <= '0;
			rd_addr <= '0;
			smp_cnt <= '0;
			rd_stop <= 1'b0;
		end else if (rd_en) begin
			smp_cnt <= smp_cnt + 1'b1;
			if (rd_last)
				rd_stop <= 1'b1;
			if (rd_bank == 3'(n_bank - 1)) begin
				rd_bank <= '0;
				rd_addr <= rd_addr + 1'b1;
			end else begin
				rd_bank <= rd_bank + 3'd1;
			end
		end
	end

	// flags trail the read by the ram register stage
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_last  <= 1'b0;
		end else begin
			out_valid <= rd_en;
			out_last  <= rd_en && rd_last;
		end
	end

	assign out_real = rd_real;
	assign out_imag = rd_imag;
	// frame is finished once its last sample leaves
	assign src_done = out_last;

endmodule

//--- verilog/mrd_top.sv
`timescale 1ns/1ns

module mrd_top import mrd_pkg::*; #(
	parameter int w_addr = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic signed [dw-1:0] in_real [n_lane],
	input  logic signed [dw-1:0] in_imag [n_lane],
	output logic                out_valid,
	output logic signed [dw-1:0] out_real,
	output logic signed [dw-1:0] out_imag,
	output logic                out_last,
	output logic                over_time
);

	mrd_st_if st_in ();
	mrd_mem_wr #(.w_addr(w_addr)) mem_wr ();

	mrd_state_e           fsm;
	logic                 sink_end;
	logic                 src_done;
	logic [w_addr:0]      frame_beats;
	logic                 rd_en;
	logic [2:0]           rd_bank;
	logic [w_addr-1:0]    rd_addr;
	logic signed [dw-1:0] rd_real;
	logic signed [dw-1:0] rd_imag;

	assign st_in.valid    = in_valid;
	assign st_in.din_real = in_real;
	assign st_in.din_imag = in_imag;

	mrd_sink #(.w_addr(w_addr)) i_sink (
		.clk         (clk),
		.rst_n       (rst_n),
		.fsm         (fsm),
		.in_data     (st_in.snk),
		.wr_ram      (mem_wr.wr),
		.sink_end    (sink_end),
		.over_time   (over_time),
		.frame_beats (frame_beats)
	);

	mrd_fsm i_fsm (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.sink_end  (sink_end),
		.over_time (over_time),
		.src_done  (src_done),
		.fsm       (fsm)
	);

	mrd_bank_ram #(.w_addr(w_addr)) i_ram (
		.clk     (clk),
		.wr_ram  (mem_wr.ram),
		.rd_en   (rd_en),
		.rd_bank (rd_bank),
		.rd_addr (rd_addr),
		.rd_real (rd_real),
		.rd_imag (rd_imag)
	);

	mrd_source #(.w_addr(w_addr)) i_source (
		.clk         (clk),
		.rst_n       (rst_n),
		.fsm         (fsm),
		.frame_beats (frame_beats),
		.rd_en       (rd_en),
		.rd_bank     (rd_bank),
		.rd_addr     (rd_addr),
		.rd_real     (rd_real),
		.rd_imag     (rd_imag),
		.out_valid   (out_valid),
		.out_real    (out_real),
		.out_imag    (out_imag),
		.out_last    (out_last),
		.src_done    (src_done)
	);

endmodule

//--- tb/mrd_tb.sv
`timescale 1ns/1ns

module mrd_tb import mrd_pkg::*; ();

	localparam int total_beats = 7 + 1 + 5 + 64 + 3 + 12 + 9 + 10;
	localparam int ot_beats    = 2100;
	localparam int margin      = 600;
	localparam int limit_ns    = (total_beats * 4 + ot_beats + margin) * 20;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic signed [dw-1:0] in_real [n_lane];
	logic signed [dw-1:0] in_imag [n_lane];
	logic                 out_valid;
	logic signed [dw-1:0] out_real;
	logic signed [dw-1:0] out_imag;
	logic                 out_last;
	logic                 over_time;

	// expected samples in natural order, {real, imag}
	logic [31:0] exp_q [$];
	logic [31:0] exp_head;
	int          exp_count;

	integer seed;
	string  test_name;
	int     mism_cnt;
	int     proto_cnt;
	int     ot_cnt;
	bit     ot_armed;
	bit     seen_edge;
	bit     frame_seen;

	mrd_top #(.w_addr(8)) i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_real   (in_real),
		.in_imag   (in_imag),
		.out_valid (out_valid),
		.out_real  (out_real),
		.out_imag  (out_imag),
		.out_last  (out_last),
		.over_time (over_time)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// retire one expected sample per output beat
	always @(posedge clk) begin
		seen_edge  <= 1'b1;
		frame_seen <= frame_seen || in_valid;
		if (over_time)
			ot_cnt <= ot_cnt + 1;
		if (rst_n && out_valid && exp_q.size() != 0)
			void'(exp_q.pop_front());
	end

	// head of the queue, settled half a cycle before the next check
	always @(negedge clk) begin
		exp_count = exp_q.size();
		exp_head  = (exp_q.size() != 0) ? exp_q[0] : 32'h0;
	end

	a_data: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && exp_count != 0 |-> {out_real, out_imag} == exp_head)
		else begin
			mism_cnt++;
			$display("MISMATCH %s expected %h actual %h", test_name, exp_head,
				{$sampled(out_real), $sampled(out_imag)});
		end

	a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> exp_count != 0)
		else begin
			proto_cnt++;
			$display("%s: output sample appeared with no input sample pending", test_name);
		end

	// last flag only on the final sample of the frame
	a_last: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out_last == (exp_count == 1))
		else begin
			proto_cnt++;
			$display("%s: out_last does not mark the final sample", test_name);
		end

	a_last_valid: assert property (@(posedge clk) disable iff (!rst_n)
		out_last |-> out_valid)
		else begin
			proto_cnt++;
			$display("%s: out_last high without out_valid", test_name);
		end

	a_no_gap: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid && !out_last |=> out_valid)
		else begin
			proto_cnt++;
			$display("%s: gap inside the output frame", test_name);
		end

	a_no_out_while_in: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !out_valid)
		else begin
			proto_cnt++;
			$display("%s: output sample while input is still arriving", test_name);
		end

	a_quiet_after_end: assert property (@(posedge clk) disable iff (!rst_n)
		i_dut.sink_end |-> !out_valid)
		else begin
			proto_cnt++;
			$display("%s: output sample in the cycle of sink_end", test_name);
		end

	a_rise_in_source: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(out_valid) |-> $past(i_dut.fsm == st_source))
		else begin
			proto_cnt++;
			$display("%s: output started before the source phase", test_name);
		end

	a_over_armed: assert property (@(posedge clk) disable iff (!rst_n)
		over_time |-> ot_armed)
		else begin
			proto_cnt++;
			$display("%s: over_time fired during a normal frame", test_name);
		end

	a_over_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		over_time |=> !over_time)
		else begin
			proto_cnt++;
			$display("%s: over_time held longer than one cycle", test_name);
		end

	// outputs stay quiet through reset and up to the first frame
	a_quiet_start: assert property (@(posedge clk)
		seen_edge && !frame_seen |-> !out_valid && !out_last && !over_time)
		else begin
			proto_cnt++;
			$display("outputs active before the first frame");
		end

	task automatic send_frame(input int beats, input bit record);
		logic [31:0] r;
		for (int b = 0; b < beats; b++) begin
			@(posedge clk);
			in_valid <= 1'b1;
			for (int l = 0; l < n_lane; l++) begin
				r = $random(seed);
				in_real[l] <= r[15:0];
				in_imag[l] <= r[31:16];
				if (record)
					exp_q.push_back({r[15:0], r[31:16]});
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_frame_done(input int beats);
		int n;
		bit done;
		n = 0;
		done = 1'b0;
		while (!done && n < 4 * beats + 20) begin
			@(posedge clk);
			done = out_last;
			n++;
		end
		if (!done) begin
			proto_cnt++;
			$display("%s: frame of %0d beats never signalled its last sample", test_name, beats);
		end
		@(negedge clk);
		assert (exp_q.size() == 0)
			else begin
				proto_cnt++;
				$display("%s: %0d samples never came out", test_name, exp_q.size());
			end
	endtask

	task automatic run_frame(input string name, input int beats, input int gap);
		test_name = name;
		send_frame(beats, 1'b1);
		wait_frame_done(beats);
		repeat (gap) @(posedge clk);
	endtask

	initial begin
		#(limit_ns);
		$display("watchdog expired, the run did not finish in time");
		$display("** FAIL **");
		$finish;
	end

	initial begin
		seed      = 53;
		rst_n     = 1'b0;
		in_valid  = 1'b0;
		test_name = "reset";
		for (int l = 0; l < n_lane; l++) begin
			in_real[l] = '0;
			in_imag[l] = '0;
		end
		repeat (5) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);

		run_frame("order_7", 7, 4);
		run_frame("len_1", 1, 2);
		run_frame("len_5", 5, 2);
		run_frame("len_64", 64, 3);

		// frames with short idle gaps
		run_frame("b2b_a", 3, 0);
		run_frame("b2b_b", 12, 1);
		run_frame("b2b_c", 9, 3);

		// sink watchdog drops an overlong frame
		test_name = "overtime";
		ot_armed  = 1'b1;
		send_frame(ot_beats, 1'b0);
		repeat (20) @(posedge clk);
		assert (ot_cnt == 1)
			else begin
				proto_cnt++;
				$display("overtime: over_time pulsed %0d times instead of once", ot_cnt);
			end
		ot_armed = 1'b0;
		run_frame("after_drop", 10, 4);

		$display("mismatches %0d, protocol errors %0d", mism_cnt, proto_cnt);
		if (mism_cnt == 0 && proto_cnt == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

//--- flist.f
verilog/mrd_pkg.sv
verilog/mrd_if.sv
verilog/mrd_sink.sv
verilog/mrd_fsm.sv
verilog/mrd_bank_ram.sv
verilog/mrd_source.sv
verilog/mrd_top.sv
tb/mrd_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mrd_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
